// File: cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
	input logic CLK,
	input logic arst_n,
	input logic load,
	input cpu_pkg::word_t inst,
	output cpu_pkg::pc_t pc,
	input cpu_pkg::byte_t rx_data,
	input logic rx_valid,
	output cpu_pkg::byte_t tx_data,
	output logic tx_valid,
	input logic tx_ready,
	output logic halted
);
	import cpu_pkg::*;

	word_t regs [32];
	word_t dmem [2**DMEM_AW];
	core_state_t state, state_next;
	pc_t pc_next, pc_inc;
	inst_t ins;
	word_t rs_val, rt_val, simm, zimm, ea;
	daddr_t daddr;
	word_t io_buf;
	logic is_in, is_out, io_byte, io_step;
	logic wr_en, mem_we;
	reg_idx_t wr_idx;
	word_t wr_data;

	assign ins = inst_t'(inst);
	assign rs_val = (ins.f.r.rs == '0) ? '0 : regs[ins.f.r.rs];
	assign rt_val = (ins.f.r.rt == '0) ? '0 : regs[ins.f.r.rt];
	assign simm = {{16{ins.f.i.imm[15]}}, ins.f.i.imm};
	assign zimm = {16'b0, ins.f.i.imm};
	assign ea = rs_val + simm;
	assign daddr = ea[DMEM_AW-1:0];
	assign pc_inc = pc + 1'b1;

	assign is_in = ins.op == OP_IN;
	assign is_out = ins.op == OP_OUT;
	assign io_byte = state inside {IO_B3, IO_B2, IO_B1, IO_B0};
	assign io_step = is_in ? rx_valid : tx_ready; // OUT stalls until the byte is taken

	assign tx_valid = is_out && io_byte;
	assign halted = state == HALT;

	always_comb begin
		case (state)
			IO_B3: tx_data = rs_val[31:24];
			IO_B2: tx_data = rs_val[23:16];
			IO_B1: tx_data = rs_val[15:8];
			default: tx_data = rs_val[7:0];
		endcase
	end

	always_comb begin
		state_next = state;
		pc_next = pc;
		wr_en = 1'b0;
		wr_idx = ins.f.r.rd;
		wr_data = '0;
		mem_we = 1'b0;
		case (state)
			EXEC: if (inst == '0) begin
				state_next = HALT;
			end else begin
				pc_next = pc_inc;
				case (ins.op)
					OP_SP: begin
						wr_en = 1'b1;
						case (ins.f.r.funct)
							FUNCT_SLL: wr_data = rt_val << ins.f.r.shamt;
							FUNCT_SRL: wr_data = rt_val >> ins.f.r.shamt;
							FUNCT_SRA: wr_data = word_t'($signed(rt_val) >>> ins.f.r.shamt);
							FUNCT_ADD: wr_data = rs_val + rt_val;
							FUNCT_SUB: wr_data = rs_val - rt_val;
							FUNCT_AND: wr_data = rs_val & rt_val;
							FUNCT_OR: wr_data = rs_val | rt_val;
							FUNCT_XOR: wr_data = rs_val ^ rt_val;
							FUNCT_SLT: wr_data = word_t'($signed(rs_val) < $signed(rt_val));
							FUNCT_JR: begin
								wr_en = 1'b0;
								pc_next = rs_val[IMEM_AW-1:0];
							end
							default: wr_en = 1'b0;
						endcase
					end
					OP_J: pc_next = ins.f.target[IMEM_AW-1:0];
					OP_JAL: begin
						pc_next = ins.f.target[IMEM_AW-1:0];
						wr_en = 1'b1;
						wr_idx = 5'd31;
						wr_data = word_t'(pc_inc);
					end
					OP_BEQ: if (rs_val == rt_val) pc_next = pc + pc_t'(ins.f.i.imm);
					OP_BNE: if (rs_val != rt_val) pc_next = pc + pc_t'(ins.f.i.imm);
					OP_ADDI, OP_ANDI, OP_ORI, OP_LW: begin
						wr_en = 1'b1;
						wr_idx = ins.f.i.rt;
						if (ins.op == OP_ADDI) wr_data = rs_val + simm;
						else if (ins.op == OP_ANDI) wr_data = rs_val & zimm;
						else if (ins.op == OP_ORI) wr_data = rs_val | zimm;
						else wr_data = dmem[daddr];
					end
					OP_SW: mem_we = 1'b1;
					OP_IN, OP_OUT: begin
						pc_next = pc;
						state_next = IO_B3;
					end
					default: ;
				endcase
			end
			IO_B3: if (io_step) state_next = IO_B2;
			IO_B2: if (io_step) state_next = IO_B1;
			IO_B1: if (io_step) state_next = IO_B0;
			IO_B0: if (io_step) state_next = IO_WAIT;
			IO_WAIT: if (is_in) begin
				wr_en = 1'b1;
				wr_data = io_buf;
				pc_next = pc_inc;
				state_next = EXEC;
			end else if (tx_ready) begin
				pc_next = pc_inc; // Last stop bit has gone out
				state_next = EXEC;
			end
			default: ;
		endcase
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= EXEC;
			pc <= '0;
			for (int i = 0; i < 32; i++) regs[i] <= '0;
			for (int j = 0; j < 2**DMEM_AW; j++) dmem[j] <= '0;
		end else if (load) begin
			state <= EXEC; // Core waits at word 0 while a program arrives
			pc <= '0;
		end else begin
			state <= state_next;
			pc <= pc_next;
			if (wr_en) regs[wr_idx] <= wr_data;
			if (mem_we) dmem[daddr] <= rt_val;
		end
	end

	// IN gathers bytes MSB first
	always_ff @(posedge CLK) begin
		if (is_in && io_byte && rx_valid) io_buf <= {io_buf[23:0], rx_data};
	end

	assert property (@(posedge CLK) disable iff (!arst_n) state == EXEC |-> !tx_valid);
	assert property (@(posedge CLK) disable iff (!arst_n)
		state == HALT |=> state != HALT || $stable(pc));

endmodule

// File: cpu_pkg.sv
package cpu_pkg;

	localparam int IMEM_AW = 5;
	localparam int DMEM_AW = 7;
	localparam int CLKS_PER_BIT = 4; // Short bit period keeps simulation fast
	localparam int BAUD_W = $clog2(CLKS_PER_BIT);

	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [IMEM_AW-1:0] pc_t;
	typedef logic [DMEM_AW-1:0] daddr_t;
	typedef logic [BAUD_W-1:0] baud_cnt_t;

	typedef enum logic [5:0] {
		OP_SP   = 6'b000000,
		OP_J    = 6'b000010,
		OP_JAL  = 6'b000011,
		OP_BEQ  = 6'b000100,
		OP_BNE  = 6'b000101,
		OP_ADDI = 6'b001000,
		OP_ANDI = 6'b001100,
		OP_ORI  = 6'b001101,
		OP_LW   = 6'b100011,
		OP_SW   = 6'b101011,
		OP_IN   = 6'b111011,
		OP_OUT  = 6'b111100
	} opcode_t;

	typedef enum logic [5:0] {
		FUNCT_SLL = 6'b000000,
		FUNCT_SRL = 6'b000010,
		FUNCT_SRA = 6'b000011,
		FUNCT_JR  = 6'b001000,
		FUNCT_ADD = 6'b100000,
		FUNCT_SUB = 6'b100010,
		FUNCT_AND = 6'b100100,
		FUNCT_OR  = 6'b100101,
		FUNCT_XOR = 6'b100110,
		FUNCT_SLT = 6'b101010
	} funct_t;

	typedef struct packed {
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		logic [4:0] shamt;
		funct_t funct;
	} rfmt_t;

	typedef struct packed {
		reg_idx_t rs;
		reg_idx_t rt;
		logic [15:0] imm;
	} ifmt_t;

	// The 26 bits below the opcode seen as R, I or J format
	typedef union packed {
		rfmt_t r;
		ifmt_t i;
		logic [25:0] target;
	} inst_body_t;

	typedef struct packed {
		opcode_t op;
		inst_body_t f;
	} inst_t;

	typedef enum logic [2:0] {EXEC, IO_B3, IO_B2, IO_B1, IO_B0, IO_WAIT, HALT} core_state_t;

	typedef enum logic [2:0] {IDLE, B0, B1, B2, B3, WRITE} loader_state_t;

endpackage

// File: cpu_top.sv
`timescale 1ns/1ns

module cpu_top (
	input logic CLK,
	input logic arst_n,
	input logic rx,
	output logic tx,
	input logic load,
	output logic halted
);
	import cpu_pkg::*;

	byte_t rx_data;
	logic rx_valid;
	byte_t tx_data;
	logic tx_valid;
	logic tx_ready;
	pc_t pc;
	word_t inst;

	uart_rx uart_rx_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.rx(rx),
		.rx_data(rx_data),
		.rx_valid(rx_valid)
	);

	uart_tx uart_tx_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.tx(tx)
	);

	// Loader and core share the receiver, selected by load
	imem_loader imem_loader_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.load(load),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.pc(pc),
		.inst(inst)
	);

	cpu_core cpu_core_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.load(load),
		.inst(inst),
		.pc(pc),
		.rx_data(rx_data),
		.rx_valid(rx_valid),
		.tx_data(tx_data),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.halted(halted)
	);

endmodule

// File: imem_loader.sv
`timescale 1ns/1ns

module imem_loader (
	input logic CLK,
	input logic arst_n,
	input logic load,
	input cpu_pkg::byte_t rx_data,
	input logic rx_valid,
	input cpu_pkg::pc_t pc,
	output cpu_pkg::word_t inst
);
	import cpu_pkg::*;

	word_t mem [2**IMEM_AW];
	word_t word_buf;
	pc_t waddr;
	loader_state_t state;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			waddr <= '0;
		end else begin
			case (state)
				IDLE: if (load) begin
					waddr <= '0; // Every upload starts over at word 0
					state <= B0;
				end
				B0: if (!load) state <= IDLE; else if (rx_valid) state <= B1;
				B1: if (!load) state <= IDLE; else if (rx_valid) state <= B2;
				B2: if (!load) state <= IDLE; else if (rx_valid) state <= B3;
				B3: if (!load) state <= IDLE; else if (rx_valid) state <= WRITE;
				WRITE: begin
					waddr <= waddr + 1'b1; // Wraps after 32 words
					state <= load ? B0 : IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (rx_valid) begin
			case (state)
				B0: word_buf[7:0] <= rx_data;
				B1: word_buf[15:8] <= rx_data;
				B2: word_buf[23:16] <= rx_data;
				B3: word_buf[31:24] <= rx_data;
				default: ;
			endcase
		end
		if (state == WRITE) mem[waddr] <= word_buf;
	end

	assign inst = mem[pc];

endmodule

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --top-module tb_cpu_top -f tb.f -o tb_sim && \
./obj_dir/tb_sim | tee /dev/stderr | grep -q "All tests passed" && \
echo "PASS" || { echo "FAIL"; exit 1; }

// File: tb.f
cpu_pkg.sv
uart_rx.sv
uart_tx.sv
imem_loader.sv
cpu_core.sv
cpu_top.sv
tb_cpu_top.sv

// File: tb_cpu_top.sv
`timescale 1ns/1ns

module tb_cpu_top;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int SEED = 51;
	localparam int NUM_TESTS = 5;
	localparam int MAX_WORDS = 16;
	localparam int FRAME_TIMEOUT = 4000; // Cycles to wait for a start bit on tx
	localparam int HALT_TIMEOUT = 500;
	localparam int QUIET_CYCLES = 20 * CLKS_PER_BIT;

	logic CLK;
	logic arst_n;
	logic rx;
	logic load;
	logic tx;
	logic halted;

	// Program, IN words and expected OUT words for each test
	word_t prog [NUM_TESTS][MAX_WORDS];
	word_t in_words [NUM_TESTS][MAX_WORDS];
	word_t exp_words [NUM_TESTS][MAX_WORDS];
	int prog_len [NUM_TESTS];
	int in_len [NUM_TESTS];
	int exp_len [NUM_TESTS];

	cpu_top cpu_top_inst (
		.CLK(CLK),
		.arst_n(arst_n),
		.rx(rx),
		.tx(tx),
		.load(load),
		.halted(halted)
	);

	function automatic word_t enc_r(funct_t fn, int rs, int rt, int rd, int sh);
		return {OP_SP, reg_idx_t'(rs), reg_idx_t'(rt), reg_idx_t'(rd), 5'(sh), fn};
	endfunction

	function automatic word_t enc_i(opcode_t op, int rs, int rt, int imm);
		return {op, reg_idx_t'(rs), reg_idx_t'(rt), 16'(imm)};
	endfunction

	function automatic word_t enc_j(opcode_t op, int target);
		return {op, 26'(target)};
	endfunction

	function automatic word_t enc_in(int rd);
		return {OP_IN, 10'd0, reg_idx_t'(rd), 11'd0};
	endfunction

	function automatic word_t enc_out(int rs);
		return {OP_OUT, reg_idx_t'(rs), 21'd0};
	endfunction

	task automatic fail_run(string what);
		$display("%s", what);
		$display("Some tests failed");
		$fatal(1);
	endtask

	task automatic check_equal(string name, word_t got, word_t exp);
		if (got !== exp)
			fail_run($sformatf("error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic add_inst(int t, word_t w);
		prog[t][prog_len[t]] = w;
		prog_len[t] = prog_len[t] + 1;
	endtask

	task automatic add_input(int t, word_t w);
		in_words[t][in_len[t]] = w;
		in_len[t] = in_len[t] + 1;
	endtask

	task automatic add_expect(int t, word_t w);
		exp_words[t][exp_len[t]] = w;
		exp_len[t] = exp_len[t] + 1;
	endtask

	task automatic build_table();
		word_t rnd;
		rnd = $urandom;
		for (int t = 0; t < NUM_TESTS; t++) begin
			prog_len[t] = 0;
			in_len[t] = 0;
			exp_len[t] = 0;
		end
		// Immediates and the first R-type group, r1 = -5 and r2 = 0x8F0F
		add_inst(0, enc_i(OP_ADDI, 0, 1, -5));
		add_inst(0, enc_out(1));
		add_inst(0, enc_i(OP_ORI, 0, 2, 16'h8F0F));
		add_inst(0, enc_out(2));
		add_inst(0, enc_i(OP_ANDI, 1, 3, 16'hF0F0));
		add_inst(0, enc_out(3));
		add_inst(0, enc_r(FUNCT_ADD, 1, 2, 4, 0));
		add_inst(0, enc_out(4));
		add_inst(0, enc_r(FUNCT_SUB, 2, 1, 5, 0));
		add_inst(0, enc_out(5));
		add_inst(0, enc_r(FUNCT_AND, 2, 3, 6, 0));
		add_inst(0, enc_out(6));
		add_inst(0, enc_r(FUNCT_OR, 2, 3, 7, 0));
		add_inst(0, enc_out(7));
		add_inst(0, 32'h0);
		add_expect(0, 32'hFFFF_FFFB);
		add_expect(0, 32'h0000_8F0F);
		add_expect(0, 32'h0000_F0F0); // ANDI zero-extends its immediate
		add_expect(0, 32'h0000_8F0A);
		add_expect(0, 32'h0000_8F14);
		add_expect(0, 32'h0000_8000);
		add_expect(0, 32'h0000_FFFF);
		// XOR, signed SLT and the three shifts
		add_inst(1, enc_i(OP_ADDI, 0, 1, -5));
		add_inst(1, enc_i(OP_ORI, 0, 2, 16'h8F0F));
		add_inst(1, enc_r(FUNCT_XOR, 2, 1, 3, 0));
		add_inst(1, enc_out(3));
		add_inst(1, enc_r(FUNCT_SLT, 1, 2, 4, 0));
		add_inst(1, enc_out(4));
		add_inst(1, enc_r(FUNCT_SLT, 2, 1, 5, 0));
		add_inst(1, enc_out(5));
		add_inst(1, enc_r(FUNCT_SLL, 0, 2, 6, 20));
		add_inst(1, enc_out(6));
		add_inst(1, enc_r(FUNCT_SRA, 0, 6, 7, 8));
		add_inst(1, enc_out(7));
		add_inst(1, enc_r(FUNCT_SRL, 0, 6, 8, 8));
		add_inst(1, enc_out(8));
		add_inst(1, 32'h0);
		add_expect(1, 32'hFFFF_70F4);
		add_expect(1, 32'h0000_0001);
		add_expect(1, 32'h0000_0000);
		add_expect(1, 32'hF0F0_0000);
		add_expect(1, 32'hFFF0_F000);
		add_expect(1, 32'h00F0_F000);
		// Stores around base 8, read back in another order
		add_inst(2, enc_i(OP_ADDI, 0, 1, 16'h1234));
		add_inst(2, enc_i(OP_ADDI, 0, 2, -2));
		add_inst(2, enc_i(OP_ORI, 0, 3, 16'hBEEF));
		add_inst(2, enc_i(OP_ADDI, 0, 4, 8));
		add_inst(2, enc_i(OP_SW, 4, 1, 0));
		add_inst(2, enc_i(OP_SW, 4, 2, 5));
		add_inst(2, enc_i(OP_SW, 4, 3, -3));
		add_inst(2, enc_i(OP_LW, 4, 5, 5));
		add_inst(2, enc_i(OP_LW, 4, 6, -3));
		add_inst(2, enc_i(OP_LW, 4, 7, 0));
		add_inst(2, enc_out(5));
		add_inst(2, enc_out(6));
		add_inst(2, enc_out(7));
		add_inst(2, 32'h0);
		add_expect(2, 32'hFFFF_FFFE);
		add_expect(2, 32'h0000_BEEF);
		add_expect(2, 32'h0000_1234);
		// Branch offsets count from the branch itself
		add_inst(3, enc_i(OP_ADDI, 0, 1, 0));
		add_inst(3, enc_i(OP_ADDI, 0, 2, 5));
		add_inst(3, enc_i(OP_ADDI, 1, 1, 1)); // Loop body at word 2
		add_inst(3, enc_i(OP_BNE, 1, 2, -1));
		add_inst(3, enc_out(1));
		add_inst(3, enc_i(OP_BEQ, 1, 2, 2)); // Taken, skips the next OUT
		add_inst(3, enc_out(0));
		add_inst(3, enc_i(OP_BEQ, 1, 0, 2)); // Not taken, so the call runs
		add_inst(3, enc_j(OP_JAL, 11));
		add_inst(3, enc_out(31));
		add_inst(3, 32'h0);
		add_inst(3, enc_i(OP_ORI, 0, 3, 16'hCAFE));
		add_inst(3, enc_out(3));
		add_inst(3, enc_r(FUNCT_JR, 31, 0, 0, 0));
		add_expect(3, 32'd5);
		add_expect(3, 32'h0000_CAFE);
		add_expect(3, 32'd9);
		// Both IN words come first so no byte arrives during an OUT
		add_inst(4, enc_in(1));
		add_inst(4, enc_in(2));
		add_inst(4, enc_i(OP_ADDI, 1, 1, 1));
		add_inst(4, enc_out(1));
		add_inst(4, enc_i(OP_ADDI, 2, 2, 1));
		add_inst(4, enc_out(2));
		add_inst(4, 32'h0);
		add_input(4, rnd);
		add_input(4, 32'hFFFF_FFFF);
		add_expect(4, rnd + 32'd1);
		add_expect(4, 32'h0);
	endtask

	task automatic send_byte(byte_t b);
		logic [9:0] frame;
		int gap;
		frame = {1'b1, b, 1'b0};
		gap = 1 + $urandom_range(0, 2 * CLKS_PER_BIT);
		for (int i = 0; i < 10; i++) begin
			@(posedge CLK);
			rx <= frame[i];
			repeat (CLKS_PER_BIT - 1) @(posedge CLK);
		end
		repeat (gap) @(posedge CLK); // Idle line between bytes
	endtask

	task automatic send_word_lsb(word_t w);
		for (int i = 0; i < 4; i++) send_byte(w[8*i +: 8]);
	endtask

	task automatic send_word_msb(word_t w);
		for (int i = 0; i < 4; i++) send_byte(w[31-8*i -: 8]);
	endtask

	task automatic receive_byte(output byte_t b);
		int waited;
		waited = 0;
		@(negedge CLK);
		while (tx !== 1'b0) begin
			if (waited == FRAME_TIMEOUT) fail_run("timeout waiting for a start bit on tx");
			waited++;
			@(negedge CLK);
		end
		repeat (CLKS_PER_BIT / 2) @(negedge CLK); // Middle of the start bit
		if (tx !== 1'b0) fail_run("start bit on tx ended too early");
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge CLK);
			b[i] = tx;
		end
		repeat (CLKS_PER_BIT) @(negedge CLK);
		if (tx !== 1'b1) fail_run("stop bit on tx is low");
	endtask

	task automatic receive_word(output word_t w);
		byte_t b;
		w = '0;
		for (int i = 0; i < 4; i++) begin
			receive_byte(b);
			w = {w[23:0], b};
		end
	endtask

	task automatic wait_for_halt();
		int waited;
		waited = 0;
		@(negedge CLK);
		while (halted !== 1'b1) begin
			if (tx !== 1'b1) fail_run("tx sent more words than expected before halting");
			if (waited == HALT_TIMEOUT) fail_run("timeout waiting for halted after the last output");
			waited++;
			@(negedge CLK);
		end
	endtask

	task automatic expect_quiet_tx();
		for (int i = 0; i < QUIET_CYCLES; i++) begin
			@(negedge CLK);
			if (tx !== 1'b1) fail_run("tx started a frame after the core halted");
		end
	endtask

	initial begin
		CLK = 1'b0;
		forever #(CLK_PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		int t;
		void'($urandom(SEED));
		arst_n = 1'b0;
		rx = 1'b1;
		load = 1'b1; // Keeps the core parked until the first program is in
		build_table();
		repeat (8) @(posedge CLK);
		arst_n <= 1'b1;
		for (t = 0; t < NUM_TESTS; t++) begin
			@(posedge CLK);
			load <= 1'b1;
			repeat (2) @(posedge CLK);
			@(negedge CLK);
			check_equal("halted", word_t'(halted), 32'd0);
			for (int i = 0; i < prog_len[t]; i++) send_word_lsb(prog[t][i]);
			repeat (2 * CLKS_PER_BIT) @(posedge CLK); // Last word reaches memory
			load <= 1'b0;
			fork
				begin
					for (int i = 0; i < in_len[t]; i++) send_word_msb(in_words[t][i]);
				end
				begin
					word_t got;
					for (int k = 0; k < exp_len[t]; k++) begin
						receive_word(got);
						check_equal($sformatf("test %0d tx word %0d", t, k), got, exp_words[t][k]);
					end
				end
			join
			wait_for_halt();
			expect_quiet_tx();
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// File: uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
	input logic CLK,
	input logic arst_n,
	input logic rx,
	output cpu_pkg::byte_t rx_data,
	output logic rx_valid
);
	import cpu_pkg::*;

	logic rx_meta;
	logic rx_s;
	logic busy;
	baud_cnt_t cnt;
	logic [3:0] bit_idx;
	byte_t shreg;
	logic sample_data;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta <= 1'b1;
			rx_s <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_s <= rx_meta;
		end
	end

	// Bits 1 to 8 of the frame carry data
	assign sample_data = busy && cnt == '0 && bit_idx != 4'd0 && bit_idx != 4'd9;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (!busy) begin
				if (!rx_s) begin
					busy <= 1'b1;
					cnt <= baud_cnt_t'(CLKS_PER_BIT / 2 - 1); // Aim at mid start bit
					bit_idx <= '0;
				end
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end else begin
				cnt <= baud_cnt_t'(CLKS_PER_BIT - 1);
				bit_idx <= bit_idx + 1'b1;
				if (bit_idx == 4'd0 && rx_s) begin
					busy <= 1'b0; // Glitch, not a real start bit
				end else if (bit_idx == 4'd9) begin
					busy <= 1'b0;
					rx_valid <= rx_s; // Framing error drops the byte
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (sample_data) shreg <= {rx_s, shreg[7:1]};
	end

	assign rx_data = shreg;

	assert property (@(posedge CLK) disable iff (!arst_n) rx_valid |=> !rx_valid);

endmodule

// File: uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
	input logic CLK,
	input logic arst_n,
	input cpu_pkg::byte_t tx_data,
	input logic tx_valid,
	output logic tx_ready,
	output logic tx
);
	import cpu_pkg::*;

	logic [9:0] frame;
	logic busy;
	baud_cnt_t cnt;
	logic [3:0] bit_idx;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			frame <= '1;
			busy <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (tx_valid) begin
				frame <= {1'b1, tx_data, 1'b0}; // Stop, data LSB first, start
				busy <= 1'b1;
				cnt <= baud_cnt_t'(CLKS_PER_BIT - 1);
				bit_idx <= '0;
			end
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end else begin
			frame <= {1'b1, frame[9:1]}; // Ones refill so the line idles high
			cnt <= baud_cnt_t'(CLKS_PER_BIT - 1);
			if (bit_idx == 4'd9) busy <= 1'b0;
			else bit_idx <= bit_idx + 1'b1;
		end
	end

	assign tx_ready = !busy;
	assign tx = frame[0];

	assert property (@(posedge CLK) disable iff (!arst_n) tx_ready |-> tx);

endmodule
